//--- hdl/host_defines.svh
// Widths, core count and register-map constants for the host device
`ifndef HOST_DEFINES_SVH
`define HOST_DEFINES_SVH

// Forward address and data widths
`define HOST_ADDR_W 20
`define HOST_DATA_W 64

// Cores with a finish flag, and trace enable outputs
`define HOST_NUM_CORE 4
`define HOST_NUM_TRACE 13

// Page field sits in the top address bits
`define HOST_PAGE_W 8
`define HOST_PAGE_TRACE 8'h00
`define HOST_PAGE_FINISH 8'h01

// Core index position within the finish page
`define HOST_CORE_LSB 3

`endif

//--- hdl/host_msg_pkg.sv
// Forward and reverse memory message types
`default_nettype none

package host_msg_pkg;

`include "host_defines.svh"

  // Single-beat message operation
  typedef enum logic [0:0]
  {
    e_mem_read  = 1'b0,
    e_mem_write = 1'b1
  } mem_op_e;

  // Byte address within the device window
  typedef logic [`HOST_ADDR_W-1:0] addr_t;

  // Payload word carried by both channels
  typedef logic [`HOST_DATA_W-1:0] dword_t;

endpackage

`default_nettype wire

//--- hdl/host_reg_pkg.sv
// Register map target and control output types
`default_nettype none

package host_reg_pkg;

`include "host_defines.svh"

  // Register selected by the address page
  typedef enum logic [1:0]
  {
    e_reg_trace  = 2'd0,
    e_reg_finish = 2'd1,
    e_reg_none   = 2'd2
  } reg_sel_e;

  // One finish flag per core
  typedef logic [`HOST_NUM_CORE-1:0] core_mask_t;

  // Core index taken from the finish page address
  typedef logic [$clog2(`HOST_NUM_CORE)-1:0] core_id_t;

  // Trace enables, bit order:
  // icache, dcache, lce, cce, dram, vm, cmt, core profile,
  // pc-gen, pc profile, branch profile, cosim, device trace
  typedef logic [`HOST_NUM_TRACE-1:0] trace_mask_t;

endpackage

`default_nettype wire

//--- hdl/host_fwd_decode.sv
// Forward channel input stage with register target decode
`timescale 1ns/1ps
`default_nettype none

`include "host_defines.svh"

module host_fwd_decode
  import host_msg_pkg::*;
  import host_reg_pkg::*;
(
  input  wire        clk_i,
  input  wire        rst_i,

  input  wire        fwd_v_i,
  input  mem_op_e    fwd_op_i,
  input  addr_t      fwd_addr_i,
  input  dword_t     fwd_data_i,
  output logic       fwd_ready_o,

  output logic       dec_v_o,
  output mem_op_e    dec_op_o,
  output addr_t      dec_addr_o,
  output dword_t     dec_data_o,
  output reg_sel_e   dec_sel_o,
  output core_id_t   dec_core_o,
  input  wire        dec_ready_i
);

  logic                    fwd_fire;
  logic [`HOST_PAGE_W-1:0] page;
  reg_sel_e                sel_n;

  // Register free, or its contents leave this cycle
  assign fwd_ready_o = ~dec_v_o | dec_ready_i;
  assign fwd_fire    = fwd_v_i & fwd_ready_o;

  assign page = fwd_addr_i[`HOST_ADDR_W-1 -: `HOST_PAGE_W];

  always_comb
  begin
    case (page)
      `HOST_PAGE_TRACE:  sel_n = e_reg_trace;
      `HOST_PAGE_FINISH: sel_n = e_reg_finish;
      default:           sel_n = e_reg_none;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      dec_v_o <= 1'b0;
    else if (fwd_ready_o)
      dec_v_o <= fwd_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (fwd_fire)
    begin
      dec_op_o   <= fwd_op_i;
      dec_addr_o <= fwd_addr_i;
      dec_data_o <= fwd_data_i;
      dec_sel_o  <= sel_n;
      dec_core_o <= fwd_addr_i[`HOST_CORE_LSB +: $bits(core_id_t)];
    end
  end

  // A stalled message keeps its decoded fields until taken
  a_dec_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (dec_v_o && !dec_ready_i) |=> (dec_v_o && $stable(dec_op_o) && $stable(dec_addr_o)
      && $stable(dec_data_o) && $stable(dec_sel_o) && $stable(dec_core_o))
  );

endmodule

`default_nettype wire

//--- hdl/host_reg_access.sv
// Finish and trace registers with the read/write stage of the pipeline
`timescale 1ns/1ps
`default_nettype none

`include "host_defines.svh"

module host_reg_access
  import host_msg_pkg::*;
  import host_reg_pkg::*;
(
  input  wire          clk_i,
  input  wire          rst_i,

  input  wire          dec_v_i,
  input  mem_op_e      dec_op_i,
  input  addr_t        dec_addr_i,
  input  dword_t       dec_data_i,
  input  reg_sel_e     dec_sel_i,
  input  core_id_t     dec_core_i,
  output logic         dec_ready_o,

  output logic         acc_v_o,
  output mem_op_e      acc_op_o,
  output addr_t        acc_addr_o,
  output dword_t       acc_data_o,
  input  wire          acc_ready_i,

  output core_mask_t   finish_o,
  output trace_mask_t  trace_en_o
);

  logic   dec_fire;
  logic   wr_en;
  dword_t rd_data;

  assign dec_ready_o = ~acc_v_o | acc_ready_i;
  assign dec_fire    = dec_v_i & dec_ready_o;
  assign wr_en       = dec_fire & (dec_op_i == e_mem_write);

  // Read result before any write of the same message lands
  always_comb
  begin
    case (dec_sel_i)
      e_reg_trace:  rd_data = dword_t'(trace_en_o);
      e_reg_finish: rd_data = dword_t'(finish_o);
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      trace_en_o <= '0;
    else if (wr_en && dec_sel_i == e_reg_trace)
      trace_en_o <= dec_data_i[`HOST_NUM_TRACE-1:0];
  end

  // Finish flags are sticky, only reset clears them
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      finish_o <= '0;
    else if (wr_en && dec_sel_i == e_reg_finish)
      finish_o[dec_core_i] <= 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      acc_v_o <= 1'b0;
    else if (dec_ready_o)
      acc_v_o <= dec_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (dec_fire)
    begin
      acc_op_o   <= dec_op_i;
      acc_addr_o <= dec_addr_i;
      acc_data_o <= rd_data;
    end
  end

  a_finish_sticky: assert property (
    @(posedge clk_i) disable iff (rst_i)
    1'b1 |=> ((~finish_o & $past(finish_o)) == '0)
  );

endmodule

`default_nettype wire

//--- hdl/host_rev_encode.sv
// Reverse channel output register
`timescale 1ns/1ps
`default_nettype none

module host_rev_encode
  import host_msg_pkg::*;
(
  input  wire      clk_i,
  input  wire      rst_i,

  input  wire      acc_v_i,
  input  mem_op_e  acc_op_i,
  input  addr_t    acc_addr_i,
  input  dword_t   acc_data_i,
  output logic     acc_ready_o,

  output logic     rev_v_o,
  output mem_op_e  rev_op_o,
  output addr_t    rev_addr_o,
  output dword_t   rev_data_o,
  input  wire      rev_ready_i
);

  logic acc_fire;

  assign acc_ready_o = ~rev_v_o | rev_ready_i;
  assign acc_fire    = acc_v_i & acc_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      rev_v_o <= 1'b0;
    else if (acc_ready_o)
      rev_v_o <= acc_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (acc_fire)
    begin
      rev_op_o   <= acc_op_i;
      rev_addr_o <= acc_addr_i;
      // Write acks carry no data
      rev_data_o <= (acc_op_i == e_mem_write) ? '0 : acc_data_i;
    end
  end

  a_rev_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (rev_v_o && !rev_ready_i) |=> (rev_v_o && $stable(rev_op_o)
      && $stable(rev_addr_o) && $stable(rev_data_o))
  );

endmodule

`default_nettype wire

//--- hdl/host_top.sv
// Host device top: decode, register access and reverse encode stages
`timescale 1ns/1ps
`default_nettype none

module host_top
  import host_msg_pkg::*;
  import host_reg_pkg::*;
(
  input  wire          clk_i,
  input  wire          rst_i,

  input  wire          fwd_v_i,
  input  mem_op_e      fwd_op_i,
  input  addr_t        fwd_addr_i,
  input  dword_t       fwd_data_i,
  output logic         fwd_ready_o,

  output logic         rev_v_o,
  output mem_op_e      rev_op_o,
  output addr_t        rev_addr_o,
  output dword_t       rev_data_o,
  input  wire          rev_ready_i,

  output core_mask_t   finish_o,
  output trace_mask_t  trace_en_o
);

  logic     dec_v;
  logic     dec_ready;
  mem_op_e  dec_op;
  addr_t    dec_addr;
  dword_t   dec_data;
  reg_sel_e dec_sel;
  core_id_t dec_core;

  logic     acc_v;
  logic     acc_ready;
  mem_op_e  acc_op;
  addr_t    acc_addr;
  dword_t   acc_data;

  host_fwd_decode u_decode (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .fwd_v_i     (fwd_v_i),
    .fwd_op_i    (fwd_op_i),
    .fwd_addr_i  (fwd_addr_i),
    .fwd_data_i  (fwd_data_i),
    .fwd_ready_o (fwd_ready_o),
    .dec_v_o     (dec_v),
    .dec_op_o    (dec_op),
    .dec_addr_o  (dec_addr),
    .dec_data_o  (dec_data),
    .dec_sel_o   (dec_sel),
    .dec_core_o  (dec_core),
    .dec_ready_i (dec_ready)
  );

  host_reg_access u_access (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .dec_v_i     (dec_v),
    .dec_op_i    (dec_op),
    .dec_addr_i  (dec_addr),
    .dec_data_i  (dec_data),
    .dec_sel_i   (dec_sel),
    .dec_core_i  (dec_core),
    .dec_ready_o (dec_ready),
    .acc_v_o     (acc_v),
    .acc_op_o    (acc_op),
    .acc_addr_o  (acc_addr),
    .acc_data_o  (acc_data),
    .acc_ready_i (acc_ready),
    .finish_o    (finish_o),
    .trace_en_o  (trace_en_o)
  );

  host_rev_encode u_encode (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .acc_v_i     (acc_v),
    .acc_op_i    (acc_op),
    .acc_addr_i  (acc_addr),
    .acc_data_i  (acc_data),
    .acc_ready_o (acc_ready),
    .rev_v_o     (rev_v_o),
    .rev_op_o    (rev_op_o),
    .rev_addr_o  (rev_addr_o),
    .rev_data_o  (rev_data_o),
    .rev_ready_i (rev_ready_i)
  );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// Testbench clock and synchronous reset source
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
  output logic clk_o,
  output logic rst_o
);

  // 10 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset held for 8 rising edges, released on a falling edge
  initial
  begin
    rst_o = 1'b1;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- verif/tb_host_top.sv
// Host device testbench: random forward messages, register model and
// in-order response checking
`timescale 1ns/1ps
`default_nettype none

`include "host_defines.svh"

module tb_host_top
  import host_msg_pkg::*;
  import host_reg_pkg::*;
();

  logic        clk;
  logic        rst;
  logic        fwd_v;
  mem_op_e     fwd_op;
  addr_t       fwd_addr;
  dword_t      fwd_data;
  logic        fwd_ready;
  logic        rev_v;
  mem_op_e     rev_op;
  addr_t       rev_addr;
  dword_t      rev_data;
  logic        rev_ready;
  core_mask_t  finish;
  trace_mask_t trace_en;

  logic [31:0] lfsr;
  trace_mask_t model_trace;
  core_mask_t  model_finish;
  mem_op_e     exp_op_q[$];
  addr_t       exp_addr_q[$];
  dword_t      exp_data_q[$];
  int          exp_edge_q[$];
  int          edge_cnt;
  int          ready_mode;
  bit          check_latency;
  bit          fwd_fired;

  tb_clock_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  host_top dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .fwd_v_i     (fwd_v),
    .fwd_op_i    (fwd_op),
    .fwd_addr_i  (fwd_addr),
    .fwd_data_i  (fwd_data),
    .fwd_ready_o (fwd_ready),
    .rev_v_o     (rev_v),
    .rev_op_o    (rev_op),
    .rev_addr_o  (rev_addr),
    .rev_data_o  (rev_data),
    .rev_ready_i (rev_ready),
    .finish_o    (finish),
    .trace_en_o  (trace_en)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] draw_bits(input int n);
    logic [63:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      val = {val[62:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
      stop_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // Register rules applied in arrival order, read result taken before the write
  task automatic record_request();
    logic [`HOST_PAGE_W-1:0] page;
    reg_sel_e                sel;
    core_id_t                core;
    dword_t                  rd;
    page = fwd_addr[`HOST_ADDR_W-1 -: `HOST_PAGE_W];
    core = fwd_addr[`HOST_CORE_LSB +: $bits(core_id_t)];
    if (page == `HOST_PAGE_TRACE)
      sel = e_reg_trace;
    else if (page == `HOST_PAGE_FINISH)
      sel = e_reg_finish;
    else
      sel = e_reg_none;
    rd = '0;
    if (sel == e_reg_trace)
    begin
      rd = dword_t'(model_trace);
      if (fwd_op == e_mem_write)
        model_trace = fwd_data[`HOST_NUM_TRACE-1:0];
    end
    else if (sel == e_reg_finish)
    begin
      rd = dword_t'(model_finish);
      if (fwd_op == e_mem_write)
        model_finish[core] = 1'b1;
    end
    exp_op_q.push_back(fwd_op);
    exp_addr_q.push_back(fwd_addr);
    exp_data_q.push_back((fwd_op == e_mem_write) ? dword_t'(0) : rd);
    exp_edge_q.push_back(edge_cnt);
  endtask

  task automatic check_response();
    int sent_edge;
    if (exp_op_q.size() == 0)
      stop_run("A response arrived while no request was outstanding");
    check_value("rev_op_o", rev_op, exp_op_q.pop_front());
    check_value("rev_addr_o", rev_addr, exp_addr_q.pop_front());
    check_value("rev_data_o", rev_data, exp_data_q.pop_front());
    sent_edge = exp_edge_q.pop_front();
    // Valid shows right after edge k+2 and is taken at edge k+3
    if (check_latency)
      check_value("rev_v_o latency", edge_cnt - sent_edge, 3);
  endtask

  // Sample between edges, then move to the next falling edge and drive
  task automatic tick();
    #1;
    if (rev_v && rev_ready)
      check_response();
    if (exp_op_q.size() == 0)
    begin
      check_value("trace_en_o", trace_en, model_trace);
      check_value("finish_o", finish, model_finish);
    end
    fwd_fired = fwd_v && fwd_ready;
    if (fwd_fired)
      record_request();
    @(negedge clk);
    edge_cnt++;
    rev_ready = (ready_mode == 0) || (draw_bits(1) != 0);
    if (fwd_fired)
      fwd_v = 1'b0;
  endtask

  // Page kind 0 trace, 1 finish, 2 unmapped, 3 any of them
  task automatic drive_message(input int page_mode);
    int                      kind;
    logic [`HOST_PAGE_W-1:0] page;
    kind = (page_mode == 3) ? int'(draw_bits(2)) : page_mode;
    if (kind == 0)
      page = `HOST_PAGE_TRACE;
    else if (kind == 1)
      page = `HOST_PAGE_FINISH;
    else
      page = 8'h02 + 8'(draw_bits(8) % 254);
    fwd_op = (draw_bits(1) != 0) ? e_mem_write : e_mem_read;
    fwd_addr = {page, 7'(draw_bits(7)), 2'(draw_bits(2)), 3'(draw_bits(3))};
    fwd_data = draw_bits(64);
    fwd_v = 1'b1;
  endtask

  task automatic run_phase(input int n_msgs, input int page_mode, input int mode,
                           input bit single);
    int sent;
    int guard;
    sent = 0;
    guard = 0;
    ready_mode = mode;
    check_latency = single && (mode == 0);
    while (sent < n_msgs)
    begin
      if (!fwd_v && (!single || exp_op_q.size() == 0) && (single || draw_bits(2) != 0))
      begin
        drive_message(page_mode);
        sent++;
      end
      tick();
      guard++;
      if (guard > 40 * n_msgs + 100)
        stop_run("Timed out while sending forward messages");
    end
    guard = 0;
    while (fwd_v || exp_op_q.size() != 0)
    begin
      tick();
      guard++;
      if (guard > 200)
        stop_run("Timed out waiting for outstanding responses");
    end
    // All responses are back, so both registers hold the model's values
    check_value("trace_en_o", trace_en, model_trace);
    check_value("finish_o", finish, model_finish);
  endtask

  initial
  begin
    int guard;
    lfsr = 32'h8dc4f678;
    fwd_v = 1'b0;
    fwd_op = e_mem_read;
    fwd_addr = '0;
    fwd_data = '0;
    rev_ready = 1'b1;
    model_trace = '0;
    model_finish = '0;
    edge_cnt = 0;
    ready_mode = 0;
    check_latency = 1'b0;

    // Reset state, once the first edge has cleared the registers
    @(posedge clk);
    guard = 0;
    do
    begin
      @(negedge clk);
      #1;
      check_value("rev_v_o", rev_v, 0);
      check_value("finish_o", finish, 0);
      check_value("trace_en_o", trace_en, 0);
      check_value("fwd_ready_o", fwd_ready, 1);
      guard++;
      if (guard > 20)
        stop_run("Timed out waiting for reset release");
    end
    while (rst);
    @(negedge clk);
    check_value("fwd_ready_o", fwd_ready, 1);

    run_phase(40, 0, 0, 0);
    run_phase(40, 1, 1, 0);
    run_phase(40, 2, 1, 0);
    run_phase(200, 3, 1, 0);
    run_phase(30, 3, 0, 1);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+hdl
hdl/host_msg_pkg.sv
hdl/host_reg_pkg.sv
hdl/host_fwd_decode.sv
hdl/host_reg_access.sv
hdl/host_rev_encode.sv
hdl/host_top.sv
verif/tb_clock_gen.sv
verif/tb_host_top.sv
